// ==== verilog/snd_params.svh ====
`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// sound rom port
`define SND_ROM_AW 15

// script window, a command byte selects one slot
`define SND_SCRIPT_SHIFT 4
`define SND_SCRIPT_BYTES 16

// opcode that terminates a script
`define SND_END_OP 8'hFF

// mixed output width
`define SND_OUT_W 9

`endif

// ==== verilog/snd_pkg.sv ====
`default_nettype none

`include "snd_params.svh"

package snd_pkg;

    typedef logic [7:0]             snd_byte_t;     // cpu latch / rom byte
    typedef logic [`SND_ROM_AW-1:0] rom_addr_t;     // 32K sound rom
    typedef logic [3:0]             psg_reg_t;      // generator register index
    typedef logic [11:0]            tone_period_t;  // fine + coarse
    typedef logic [9:0]             psg_sound_t;    // one generator, 3 channels summed
    typedef logic [`SND_OUT_W-1:0]  snd_out_t;      // after saturation

    // register write, shared by both generators
    typedef struct packed {
        logic      wr;      // one clk strobe
        logic      chip;    // 0 or 1
        psg_reg_t  addr;
        snd_byte_t data;
    } psg_wr_t;

    // script walker
    typedef enum logic [2:0] {
        IDLE,
        FETCH_OP,
        FETCH_DATA,
        WRITE,
        DONE
    } seq_state_t;

endpackage

`default_nettype wire

// ==== verilog/snd_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module snd_latch (
    input  wire                 clk,
    input  wire                 rst,
    input  wire snd_pkg::snd_byte_t main_dout,
    input  wire                 main_latch0_cs,
    input  wire                 main_latch1_cs,
    input  wire                 cmd_take,
    output snd_pkg::snd_byte_t  cmd,
    output snd_pkg::snd_byte_t  param,
    output logic                cmd_pending
);
    import snd_pkg::*;

    // command bytes, written straight from the main cpu bus
    always_ff @(posedge clk) begin
        if (main_latch0_cs)
            cmd <= main_dout;
        if (main_latch1_cs)
            param <= main_dout;   // script parameter
    end

    // pending flag
    // a new write wins over a take in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_pending <= 1'b0;
        end else if (main_latch0_cs) begin
            cmd_pending <= 1'b1;  // re-arm, old command is overwritten
        end else if (cmd_take) begin
            cmd_pending <= 1'b0;
        end
    end

    // sequencer only takes what is waiting here
    a_take_pending: assert property (
        @(posedge clk) disable iff (rst)
        cmd_take |-> cmd_pending
    );

endmodule

`default_nettype wire

// ==== verilog/snd_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snd_params.svh"

module snd_seq (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen3,
    input  wire snd_pkg::snd_byte_t cmd,
    input  wire snd_pkg::snd_byte_t param,
    input  wire                 cmd_pending,
    output logic                cmd_take,
    output logic                rom_cs,
    output snd_pkg::rom_addr_t  rom_addr,
    input  wire snd_pkg::snd_byte_t rom_data,
    input  wire                 rom_ok,
    output snd_pkg::psg_wr_t    psg_wr
);
    import snd_pkg::*;

    localparam int OFS_W = $clog2(`SND_SCRIPT_BYTES);

    seq_state_t       state;
    logic [OFS_W-1:0] offset;     // byte within the script window
    logic             win_end;    // last pair of the window fetched
    logic             wr_q;
    snd_byte_t        cur_cmd;    // command of the running script
    snd_byte_t        op_q;
    snd_byte_t        data_q;
    logic             byte_in;    // rom answered this cen3

    // only sampled on cen3
    assign byte_in  = rom_cs && rom_ok;
    assign cmd_take = cen3 && (state == IDLE) && cmd_pending;

    // script base + running offset
    assign rom_addr = (rom_addr_t'(cur_cmd) << `SND_SCRIPT_SHIFT) | rom_addr_t'(offset);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            rom_cs  <= 1'b0;
            offset  <= '0;
            win_end <= 1'b0;
            wr_q    <= 1'b0;
        end else begin
            wr_q <= 1'b0;  // single clk strobe
            if (cen3) begin
                case (state)
                    IDLE: if (cmd_pending) begin
                        state   <= FETCH_OP;
                        offset  <= '0;
                        win_end <= 1'b0;
                    end
                    FETCH_OP: begin
                        if (!rom_cs) begin
                            rom_cs <= 1'b1;      // request opcode
                        end else if (byte_in) begin
                            rom_cs <= 1'b0;
                            offset <= offset + 1'b1;
                            state  <= (rom_data == `SND_END_OP) ? DONE : FETCH_DATA;
                        end
                    end
                    FETCH_DATA: begin
                        if (!rom_cs) begin
                            rom_cs <= 1'b1;      // request data byte
                        end else if (byte_in) begin
                            rom_cs  <= 1'b0;
                            offset  <= offset + 1'b1;
                            win_end <= (offset == OFS_W'(`SND_SCRIPT_BYTES - 1));
                            state   <= WRITE;
                        end
                    end
                    WRITE: begin
                        wr_q  <= 1'b1;
                        state <= win_end ? DONE : FETCH_OP;  // window exhausted
                    end
                    DONE:    state <= IDLE;
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // opcode and data of the current pair
    always_ff @(posedge clk) begin
        if (cmd_take)
            cur_cmd <= cmd;
        if (cen3 && byte_in && state == FETCH_OP)
            op_q <= rom_data;
        if (cen3 && byte_in && state == FETCH_DATA)
            data_q <= op_q[4] ? param : rom_data;  // bit 4 picks latch 1
    end

    assign psg_wr.wr   = wr_q;
    assign psg_wr.chip = op_q[6];
    assign psg_wr.addr = op_q[3:0];
    assign psg_wr.data = data_q;

    // rom request held through a stall
    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> $stable(rom_addr)
    );

    a_wr_pulse: assert property (
        @(posedge clk) disable iff (rst)
        psg_wr.wr |=> !psg_wr.wr
    );

endmodule

`default_nettype wire

// ==== verilog/snd_psg.sv ====
`timescale 1ns/1ps
`default_nettype none

module snd_psg (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen,
    input  wire                 wr_en,
    input  wire snd_pkg::psg_wr_t wr,
    output snd_pkg::psg_sound_t sound
);
    import snd_pkg::*;

    localparam int NREG = 11;   // tone 0..5, enable 7, volume 8..10

    snd_byte_t  regs [NREG];
    logic [2:0] chan_on;        // square bit after tone disable
    psg_sound_t chan_lvl [3];
    psg_sound_t level;

    // register file, 6 is unused here (noise period)
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREG; i++)
                regs[i] <= '0;
        end else if (wr_en && wr.wr && wr.addr < 4'(NREG)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    for (genvar n = 0; n < 3; n++) begin : g_chan
        tone_period_t period;
        tone_period_t cnt;
        logic         tone_q;

        assign period = {regs[2*n+1][3:0], regs[2*n]};  // coarse:fine

        always_ff @(posedge clk) begin
            if (rst) begin
                cnt    <= '0;
                tone_q <= 1'b0;
            end else if (cen) begin
                if (cnt >= period) begin
                    cnt    <= '0;
                    tone_q <= ~tone_q;   // half period done
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end

        // disabled channel sits high
        assign chan_on[n]  = tone_q | regs[7][n];
        assign chan_lvl[n] = chan_on[n] ? psg_sound_t'({regs[8+n][3:0], 4'b0000}) : '0;
    end

    always_comb begin
        level = chan_lvl[0] + chan_lvl[1] + chan_lvl[2];  // max 720, fits
    end

    always_ff @(posedge clk) begin
        if (rst)
            sound <= '0;
        else if (cen)
            sound <= level;
    end

endmodule

`default_nettype wire

// ==== verilog/snd_mix.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snd_params.svh"

module snd_mix (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen,
    input  wire snd_pkg::psg_sound_t sound0,
    input  wire snd_pkg::psg_sound_t sound1,
    output snd_pkg::snd_out_t   snd
);
    import snd_pkg::*;

    logic [$bits(psg_sound_t):0] sum;   // one guard bit

    assign sum = {1'b0, sound0} + {1'b0, sound1};

    // saturate instead of wrapping
    always_ff @(posedge clk) begin
        if (rst)
            snd <= '0;
        else if (cen)
            snd <= (sum > (2**`SND_OUT_W - 1)) ? '1 : sum[`SND_OUT_W-1:0];
    end

endmodule

`default_nettype wire

// ==== verilog/snd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module snd_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen3,      // 3 MHz
    input  wire                 cen1p5,    // 1.5 MHz, every 2nd cen3
    input  wire snd_pkg::snd_byte_t main_dout,
    input  wire                 main_latch0_cs,
    input  wire                 main_latch1_cs,
    output wire                 rom_cs,
    output wire snd_pkg::rom_addr_t rom_addr,
    input  wire snd_pkg::snd_byte_t rom_data,
    input  wire                 rom_ok,
    output wire snd_pkg::snd_out_t  snd
);
    import snd_pkg::*;

    snd_byte_t  cmd;
    snd_byte_t  param;
    logic       cmd_pending;
    logic       cmd_take;
    psg_wr_t    psg_wr;     // one bus, both chips
    psg_sound_t sound0;
    psg_sound_t sound1;

    snd_latch u_latch (
        .clk            (clk),
        .rst            (rst),
        .main_dout      (main_dout),
        .main_latch0_cs (main_latch0_cs),
        .main_latch1_cs (main_latch1_cs),
        .cmd_take       (cmd_take),
        .cmd            (cmd),
        .param          (param),
        .cmd_pending    (cmd_pending)
    );

    snd_seq u_seq (
        .clk         (clk),
        .rst         (rst),
        .cen3        (cen3),
        .cmd         (cmd),
        .param       (param),
        .cmd_pending (cmd_pending),
        .cmd_take    (cmd_take),
        .rom_cs      (rom_cs),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .psg_wr      (psg_wr)
    );

    snd_psg u_psg0 (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen1p5),
        .wr_en (psg_wr.chip == 1'b0),  // chip 0
        .wr    (psg_wr),
        .sound (sound0)
    );

    snd_psg u_psg1 (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen1p5),
        .wr_en (psg_wr.chip == 1'b1),  // chip 1
        .wr    (psg_wr),
        .sound (sound1)
    );

    snd_mix u_mix (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen1p5),
        .sound0 (sound0),
        .sound1 (sound1),
        .snd    (snd)
    );

endmodule

`default_nettype wire

// ==== bench/snd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snd_params.svh"

module snd_tb;

    localparam int LIMIT = 20000;   // cycles, roughly 4x the whole run

    logic        clk;
    logic        rst;
    logic        cen3;
    logic        cen1p5;
    logic [7:0]  main_dout;
    logic        main_latch0_cs;
    logic        main_latch1_cs;
    logic        rom_cs;
    logic [14:0] rom_addr;
    logic [7:0]  rom_data;
    logic        rom_ok;
    logic [8:0]  snd;

    logic [7:0]  rom [32768];
    logic [7:0]  model [2][16];      // register image of both generators
    logic [14:0] exp_addr [$];
    logic [14:0] got_addr [$];
    logic [31:0] lfsr = 32'h0922a5aa;
    logic [3:0]  phase = '0;         // 16 clk per cen1p5
    logic        busy = 1'b0;        // rom request in flight
    logic [14:0] held;               // address of that request
    logic [1:0]  stall;
    logic [7:0]  param_q;            // last byte put in latch 1
    logic [14:0] wbase;
    int          wp;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    int          cycles = 0;

    snd_top dut (
        .clk            (clk),
        .rst            (rst),
        .cen3           (cen3),
        .cen1p5         (cen1p5),
        .main_dout      (main_dout),
        .main_latch0_cs (main_latch0_cs),
        .main_latch1_cs (main_latch1_cs),
        .rom_cs         (rom_cs),
        .rom_addr       (rom_addr),
        .rom_data       (rom_data),
        .rom_ok         (rom_ok),
        .snd            (snd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    // enables and rom answer, all set on the falling edge
    always @(negedge clk) begin
        phase  = phase + 1'b1;
        cen3   = (phase[2:0] == 3'd0);
        cen1p5 = (phase == 4'd0);      // every 2nd cen3
        rom_ok = 1'b0;
        if (rst) begin
            busy = 1'b0;
        end else if (rom_cs) begin
            if (!busy) begin
                busy = 1'b1;
                held = rom_addr;
                repeat (2) begin         // 0..3 cen3 of stall
                    lfsr  = lfsr_step(lfsr);
                    stall = {stall[0], lfsr[0]};
                end
            end else begin
                check_val("rom_addr", held, rom_addr);  // no move during a stall
            end
            if (cen3) begin
                if (stall == 2'd0) begin
                    rom_ok   = 1'b1;
                    rom_data = rom[rom_addr];
                    got_addr.push_back(rom_addr);
                    busy     = 1'b0;
                end else begin
                    stall = stall - 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, the sequencer never finished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_val(input string sig, input logic [31:0] exp,
                             input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %0t %s expected %0d got %0d", $time, sig, exp, act);
            errors++;
        end
    endtask

    task report_test(input string name, input int e0);
        if (errors == e0) begin
            passed++;
            $display("test %s passed", name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", name, errors - e0);
        end
    endtask

    task cpu_write(input logic sel, input logic [7:0] val);
        @(negedge clk);
        main_dout = val;
        if (sel) begin
            main_latch1_cs = 1'b1;
            param_q        = val;
        end else begin
            main_latch0_cs = 1'b1;
        end
        @(negedge clk);
        main_latch0_cs = 1'b0;
        main_latch1_cs = 1'b0;
    endtask

    task begin_script(input logic [7:0] cmd);
        wbase = 15'(cmd) << `SND_SCRIPT_SHIFT;
        wp    = 0;
    endtask

    task add_pair(input logic [7:0] op, input logic [7:0] data);
        rom[wbase + wp]     = op;
        rom[wbase + wp + 1] = data;
        wp += 2;
    endtask

    task end_script();
        if (wp < `SND_SCRIPT_BYTES)
            rom[wbase + wp] = `SND_END_OP;
    endtask

    // walk the script as the sound cpu would, fetches and register writes
    task expect_script(input logic [7:0] cmd);
        logic [14:0] base;
        logic [7:0]  op;
        logic [7:0]  data;
        int          i;
        base = 15'(cmd) << `SND_SCRIPT_SHIFT;
        i    = 0;
        while (i < `SND_SCRIPT_BYTES) begin
            op = rom[base + i];
            exp_addr.push_back(base + 15'(i));
            i++;
            if (op == `SND_END_OP)
                break;
            data = op[4] ? param_q : rom[base + i];   // latch 1 substitution
            exp_addr.push_back(base + 15'(i));
            i++;
            if (op[3:0] < 4'd11)
                model[op[6]][op[3:0]] = data;
        end
    endtask

    // tone disabled channels sit high, enabled ones count as silent here
    function automatic int expected_snd();
        int s;
        s = 0;
        for (int c = 0; c < 2; c++)
            for (int n = 0; n < 3; n++)
                if (model[c][7][n])
                    s += 16 * model[c][8 + n][3:0];
        return (s > 511) ? 511 : s;
    endfunction

    task wait_ticks(input int n);
        repeat (n) begin
            do @(posedge clk); while (!cen1p5);
        end
    endtask

    // script over, then 2 cen1p5 for the generator and mixer stages
    task settle();
        while (got_addr.size() < exp_addr.size())
            @(negedge clk);
        wait_ticks(2);
        @(negedge clk);
        if (got_addr.size() != exp_addr.size()) begin
            $display("ERROR %0t fetch count expected %0d got %0d", $time,
                     exp_addr.size(), got_addr.size());
            errors++;
        end else begin
            foreach (exp_addr[i])
                check_val("rom_addr", exp_addr[i], got_addr[i]);
        end
        got_addr.delete();
        exp_addr.delete();
    endtask

    task run_cmd(input logic [7:0] cmd);
        cpu_write(1'b0, cmd);
        expect_script(cmd);
        settle();
    endtask

    task test_reset();
        int e0;
        e0 = errors;
        repeat (50) begin
            @(negedge clk);
            check_val("rom_cs", 0, rom_cs);
            check_val("snd", 0, snd);
        end
        report_test("reset", e0);
    endtask

    task test_fetch();
        int e0;
        e0 = errors;
        begin_script(8'h12);
        add_pair(8'h07, 8'h3F);   // all tones off on chip 0
        add_pair(8'h08, 8'h01);
        add_pair(8'h09, 8'h02);
        end_script();
        run_cmd(8'h12);
        report_test("fetch", e0);
    endtask

    task test_volume();
        int e0;
        e0 = errors;
        begin_script(8'h20);
        add_pair(8'h08, 8'h03);
        add_pair(8'h09, 8'h04);
        add_pair(8'h0A, 8'h05);
        add_pair(8'h47, 8'h07);   // chip 1 tones off
        add_pair(8'h48, 8'h01);
        add_pair(8'h49, 8'h02);
        add_pair(8'h4A, 8'h06);
        end_script();
        run_cmd(8'h20);
        check_val("snd", expected_snd(), snd);
        report_test("volume", e0);
    endtask

    task test_param();
        int e0;
        e0 = errors;
        begin_script(8'h21);
        add_pair(8'h1A, 8'hEE);   // volume 10 from latch 1
        end_script();
        cpu_write(1'b1, 8'h07);
        run_cmd(8'h21);
        check_val("snd", expected_snd(), snd);
        cpu_write(1'b1, 8'h02);
        run_cmd(8'h21);
        check_val("snd", expected_snd(), snd);
        report_test("param", e0);
    endtask

    task test_clamp();
        int e0;
        e0 = errors;
        begin_script(8'h22);
        add_pair(8'h08, 8'h0F);
        add_pair(8'h09, 8'h0F);
        add_pair(8'h0A, 8'h0F);
        add_pair(8'h48, 8'h0F);
        add_pair(8'h49, 8'h0F);
        add_pair(8'h4A, 8'h0F);
        end_script();
        run_cmd(8'h22);
        check_val("snd", 511, snd);
        report_test("clamp", e0);
    endtask

    task test_tone();
        int e0;
        bit seen0;
        bit seen240;
        e0      = errors;
        seen0   = 1'b0;
        seen240 = 1'b0;
        begin_script(8'h30);      // silence the rest
        add_pair(8'h09, 8'h00);
        add_pair(8'h0A, 8'h00);
        add_pair(8'h48, 8'h00);
        add_pair(8'h49, 8'h00);
        add_pair(8'h4A, 8'h00);
        end_script();
        begin_script(8'h31);      // channel 0 only, period 3
        add_pair(8'h00, 8'h03);
        add_pair(8'h01, 8'h00);
        add_pair(8'h07, 8'hFE);
        add_pair(8'h08, 8'h0F);
        end_script();
        begin_script(8'h32);
        add_pair(8'h48, 8'h00);
        end_script();
        run_cmd(8'h30);
        cpu_write(1'b0, 8'h31);
        expect_script(8'h31);
        while (got_addr.size() == 0)
            @(negedge clk);
        cpu_write(1'b0, 8'h32);   // must wait for the end opcode
        expect_script(8'h32);
        settle();
        repeat (40) begin
            wait_ticks(1);
            @(negedge clk);
            if (snd == 9'd0) begin
                seen0 = 1'b1;
            end else if (snd == 9'd240) begin
                seen240 = 1'b1;
            end else begin
                $display("ERROR %0t snd expected 0 or 240 got %0d", $time, snd);
                errors++;
            end
        end
        if (!(seen0 && seen240)) begin
            $display("tone output did not alternate between 0 and 240");
            errors++;
        end
        report_test("tone", e0);
    endtask

    initial begin
        rst            = 1'b1;
        cen3           = 1'b0;
        cen1p5         = 1'b0;
        main_dout      = '0;
        main_latch0_cs = 1'b0;
        main_latch1_cs = 1'b0;
        rom_data       = '0;
        rom_ok         = 1'b0;
        param_q        = '0;
        for (int a = 0; a < 32768; a++)
            rom[a] = a[7:0] ^ {1'b0, a[14:8]};   // filler, never an end opcode slot
        for (int c = 0; c < 2; c++)
            for (int r = 0; r < 16; r++)
                model[c][r] = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_fetch();
        test_volume();
        test_param();
        test_clamp();
        test_tone();
        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== snd_top.f ====
+incdir+verilog
verilog/snd_pkg.sv
verilog/snd_latch.sv
verilog/snd_seq.sv
verilog/snd_psg.sv
verilog/snd_mix.sv
verilog/snd_top.sv
bench/snd_tb.sv

// ==== Bender.yml ====
package:
  name: snd_top

sources:
  - target: any(rtl, test)
    include_dirs:
      - verilog
    files:
      - verilog/snd_pkg.sv
      - verilog/snd_latch.sv
      - verilog/snd_seq.sv
      - verilog/snd_psg.sv
      - verilog/snd_mix.sv
      - verilog/snd_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/snd_tb.sv
